// File: hdl/periph_pkg.sv
//------------------------------
// Peripheral bus package
// Address map, widths, queue depths and payloads
//------------------------------
package periph_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int CODE_W = 8;

    // Region nibble in address bits 31..28
    localparam logic [3:0] REGION_PERIPH = 4'h2;

    // Device field in address bits 15..12
    localparam logic [3:0] DEV_DISPLAY = 4'h1;
    localparam logic [3:0] DEV_UART    = 4'h2;
    localparam logic [3:0] DEV_KBD     = 4'h5;
    localparam logic [3:0] DEV_SD      = 4'h6;

    // Register offsets in address bits 11..0
    localparam logic [11:0] OFS_DATA   = 12'h000;
    localparam logic [11:0] OFS_STATUS = 12'h004;
    localparam logic [11:0] OFS_CODE   = 12'h004;

    // Queue depths, also the credits each producer starts with
    localparam int REQ_DEPTH  = 4;
    localparam int UART_DEPTH = 16;
    localparam int KBD_DEPTH  = 8;

    typedef logic [CODE_W-1:0] code_t;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_DISPLAY,
        TGT_UART_DATA,
        TGT_UART_STATUS,
        TGT_KBD_STATUS,
        TGT_KBD_CODE,
        TGT_SD
    } dev_e;

    typedef struct packed {
        logic              we;
        dev_e              target;
        logic [DATA_W-1:0] wdata;
    } dec_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

endpackage

// File: hdl/credit_fifo.sv
//------------------------------
// Credit FIFO
// Circular queue, one credit back per dequeue
//------------------------------
`timescale 1ns/1ns

module credit_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic reset_i,
    input  logic enq_i,
    input  T     enq_data_i,
    input  logic deq_i,
    output T     deq_data_o,
    output logic empty_o,
    output logic credit_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_deq;

    assign empty_o    = (count == '0);
    assign deq_data_o = mem[rd_ptr];
    assign do_deq     = deq_i && !empty_o;

    always_ff @(posedge clk) begin
        if (enq_i) begin
            mem[wr_ptr] <= enq_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            // Credit goes back one cycle after the entry leaves
            credit_o <= do_deq;
            if (enq_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({enq_i, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer must hold a credit for every entry it pushes
    assert property (@(posedge clk) disable iff (reset_i) enq_i |-> (count < DEPTH))
        else $error("credit_fifo: enqueue while full");

    assert property (@(posedge clk) disable iff (reset_i) deq_i |-> !empty_o)
        else $error("credit_fifo: dequeue while empty");

endmodule

// File: hdl/code_capture.sv
//------------------------------
// Code capture
// Admits strobed codes against queue credits
//------------------------------
`timescale 1ns/1ns

module code_capture import periph_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  strobe_i,
    input  code_t code_i,
    input  logic  credit_i,
    output logic  enq_o,
    output code_t enq_data_o,
    output logic  overflow_o
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CNT_W-1:0] credits;
    logic             admit;

    assign admit = strobe_i && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            credits    <= CNT_W'(DEPTH);
            enq_o      <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            enq_o <= admit;
            case ({admit, credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            // Sticky, a lost code stays reported
            if (strobe_i && !admit) begin
                overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (admit) begin
            enq_data_o <= code_i;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i) credits <= DEPTH)
        else $error("code_capture: credit count above queue depth");

endmodule

// File: hdl/addr_decode.sv
//------------------------------
// Address decode stage
// Pops requests and picks the target register
//------------------------------
`timescale 1ns/1ns

module addr_decode import periph_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     req_empty_i,
    input  bus_req_t req_i,
    output logic     req_deq_o,
    output logic     dec_valid_o,
    output dec_req_t dec_o
);

    logic [3:0]  region;
    logic [3:0]  dev_field;
    logic [11:0] ofs;
    dev_e        target;

    assign region    = req_i.addr[ADDR_W-1 -: 4];
    assign dev_field = req_i.addr[15:12];
    assign ofs       = req_i.addr[11:0];

    // Register stage never stalls, so take the head whenever present
    assign req_deq_o = !req_empty_i;

    always_comb begin
        target = TGT_NONE;
        if (region == REGION_PERIPH) begin
            case (dev_field)
                DEV_DISPLAY: begin
                    if (ofs == OFS_DATA) begin
                        target = TGT_DISPLAY;
                    end
                end
                DEV_UART: begin
                    if (ofs == OFS_DATA) begin
                        target = TGT_UART_DATA;
                    end else if (ofs == OFS_STATUS) begin
                        target = TGT_UART_STATUS;
                    end
                end
                DEV_KBD: begin
                    // Keyboard status sits at offset 0
                    if (ofs == OFS_DATA) begin
                        target = TGT_KBD_STATUS;
                    end else if (ofs == OFS_CODE) begin
                        target = TGT_KBD_CODE;
                    end
                end
                DEV_SD: begin
                    if (ofs == OFS_DATA) begin
                        target = TGT_SD;
                    end
                end
                default: begin
                    target = TGT_NONE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= req_deq_o;
        end
    end

    always_ff @(posedge clk) begin
        if (req_deq_o) begin
            dec_o <= '{we: req_i.we, target: target, wdata: req_i.wdata};
        end
    end

endmodule

// File: hdl/periph_regs.sv
//------------------------------
// Peripheral register stage
// Device registers, queue pops and responses
//------------------------------
`timescale 1ns/1ns

module periph_regs import periph_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,

    input  logic     dec_valid_i,
    input  dec_req_t dec_i,

    input  logic     uart_empty_i,
    input  code_t    uart_head_i,
    output logic     uart_deq_o,
    input  logic     uart_tx_busy_i,
    output logic     uart_tx_strobe_o,
    output code_t    uart_tx_data_o,

    input  logic     kbd_empty_i,
    input  code_t    kbd_head_i,
    output logic     kbd_deq_o,
    input  logic     kbd_overflow_i,

    input  logic     sd_miso_i,
    output logic     sd_sclk_o,
    output logic     sd_csn_o,
    output logic     sd_mosi_o,

    output logic [7:0] display_o,

    output logic     rsp_valid_o,
    output logic     rsp_we_o,
    output bus_rsp_t rsp_rdata_o
);

    localparam int PAD_W = DATA_W - CODE_W;

    logic              wr;
    logic              display_we;
    logic              sd_we;
    logic              tx_we;
    logic [DATA_W-1:0] rd_data;
    code_t             uart_code_r;
    code_t             kbd_code_r;

    assign wr         = dec_valid_i && dec_i.we;
    assign display_we = wr && (dec_i.target == TGT_DISPLAY);
    assign sd_we      = wr && (dec_i.target == TGT_SD);
    assign tx_we      = wr && (dec_i.target == TGT_UART_DATA);

    // Status write moves the queue head into the latched code
    assign uart_deq_o = wr && (dec_i.target == TGT_UART_STATUS) && !uart_empty_i;
    assign kbd_deq_o  = wr && (dec_i.target == TGT_KBD_STATUS) && !kbd_empty_i;

    always_comb begin
        rd_data = '0;
        case (dec_i.target)
            TGT_UART_DATA: begin
                rd_data = {{PAD_W{1'b0}}, uart_code_r};
            end
            TGT_UART_STATUS: begin
                rd_data = {{(DATA_W-2){1'b0}}, !uart_empty_i, uart_tx_busy_i};
            end
            TGT_KBD_STATUS: begin
                rd_data = {{(DATA_W-2){1'b0}}, kbd_overflow_i, !kbd_empty_i};
            end
            TGT_KBD_CODE: begin
                rd_data = {{PAD_W{1'b0}}, kbd_code_r};
            end
            TGT_SD: begin
                rd_data = {{(DATA_W-1){1'b0}}, sd_miso_i};
            end
            default: begin
                // Display is write only, unmapped reads give zero
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o        <= 8'd0;
            {sd_sclk_o, sd_csn_o, sd_mosi_o} <= 3'b010;
            uart_tx_strobe_o <= 1'b0;
            rsp_valid_o      <= 1'b0;
        end else begin
            rsp_valid_o      <= dec_valid_i;
            uart_tx_strobe_o <= tx_we;
            if (display_we) begin
                display_o <= dec_i.wdata[7:0];
            end
            // Chip select is written active high, driven active low
            if (sd_we) begin
                {sd_sclk_o, sd_csn_o, sd_mosi_o} <=
                    {dec_i.wdata[2], ~dec_i.wdata[1], dec_i.wdata[0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_we) begin
            uart_tx_data_o <= dec_i.wdata[CODE_W-1:0];
        end
        if (uart_deq_o) begin
            uart_code_r <= uart_head_i;
        end
        if (kbd_deq_o) begin
            kbd_code_r <= kbd_head_i;
        end
        if (dec_valid_i) begin
            rsp_we_o          <= dec_i.we;
            rsp_rdata_o.rdata <= dec_i.we ? '0 : rd_data;
        end
    end

endmodule

// File: hdl/periph_bus_top.sv
//------------------------------
// Peripheral bus top
// Request queue, code queues and pipeline stages
//------------------------------
`timescale 1ns/1ns

module periph_bus_top import periph_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,

    input  logic              req_valid_i,
    input  logic              req_we_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    output logic              req_credit_o,

    output logic              rsp_valid_o,
    output logic              rsp_we_o,
    output bus_rsp_t          rsp_rdata_o,

    input  logic              uart_rx_valid_i,
    input  code_t             uart_rx_data_i,
    input  logic              uart_tx_busy_i,
    output logic              uart_tx_strobe_o,
    output code_t             uart_tx_data_o,

    input  logic              kbd_strobe_i,
    input  code_t             kbd_code_i,

    input  logic              sd_miso_i,
    output logic              sd_sclk_o,
    output logic              sd_csn_o,
    output logic              sd_mosi_o,

    output logic [7:0]        display_o
);

    // Request path
    bus_req_t req_in;
    bus_req_t req_head;
    logic     req_empty;
    logic     req_deq;
    logic     dec_valid;
    dec_req_t dec;

    // UART receive path
    logic     uart_enq;
    code_t    uart_enq_data;
    logic     uart_deq;
    code_t    uart_head;
    logic     uart_empty;
    logic     uart_credit;

    // Keyboard path
    logic     kbd_enq;
    code_t    kbd_enq_data;
    logic     kbd_deq;
    code_t    kbd_head;
    logic     kbd_empty;
    logic     kbd_credit;
    logic     kbd_overflow;

    assign req_in = '{we: req_we_i, addr: req_addr_i, wdata: req_wdata_i};

    credit_fifo #(.T(bus_req_t), .DEPTH(REQ_DEPTH)) req_fifo (
        .clk(clk), .reset_i(reset_i),
        .enq_i(req_valid_i), .enq_data_i(req_in),
        .deq_i(req_deq), .deq_data_o(req_head),
        .empty_o(req_empty), .credit_o(req_credit_o)
    );

    code_capture #(.DEPTH(UART_DEPTH)) uart_capture (
        .clk(clk), .reset_i(reset_i),
        .strobe_i(uart_rx_valid_i), .code_i(uart_rx_data_i),
        .credit_i(uart_credit),
        .enq_o(uart_enq), .enq_data_o(uart_enq_data),
        .overflow_o()
    );

    credit_fifo #(.T(code_t), .DEPTH(UART_DEPTH)) uart_fifo (
        .clk(clk), .reset_i(reset_i),
        .enq_i(uart_enq), .enq_data_i(uart_enq_data),
        .deq_i(uart_deq), .deq_data_o(uart_head),
        .empty_o(uart_empty), .credit_o(uart_credit)
    );

    code_capture #(.DEPTH(KBD_DEPTH)) kbd_capture (
        .clk(clk), .reset_i(reset_i),
        .strobe_i(kbd_strobe_i), .code_i(kbd_code_i),
        .credit_i(kbd_credit),
        .enq_o(kbd_enq), .enq_data_o(kbd_enq_data),
        .overflow_o(kbd_overflow)
    );

    credit_fifo #(.T(code_t), .DEPTH(KBD_DEPTH)) kbd_fifo (
        .clk(clk), .reset_i(reset_i),
        .enq_i(kbd_enq), .enq_data_i(kbd_enq_data),
        .deq_i(kbd_deq), .deq_data_o(kbd_head),
        .empty_o(kbd_empty), .credit_o(kbd_credit)
    );

    addr_decode decode (
        .clk(clk), .reset_i(reset_i),
        .req_empty_i(req_empty), .req_i(req_head), .req_deq_o(req_deq),
        .dec_valid_o(dec_valid), .dec_o(dec)
    );

    periph_regs regs (
        .clk(clk), .reset_i(reset_i),
        .dec_valid_i(dec_valid), .dec_i(dec),
        .uart_empty_i(uart_empty), .uart_head_i(uart_head), .uart_deq_o(uart_deq),
        .uart_tx_busy_i(uart_tx_busy_i),
        .uart_tx_strobe_o(uart_tx_strobe_o), .uart_tx_data_o(uart_tx_data_o),
        .kbd_empty_i(kbd_empty), .kbd_head_i(kbd_head), .kbd_deq_o(kbd_deq),
        .kbd_overflow_i(kbd_overflow),
        .sd_miso_i(sd_miso_i), .sd_sclk_o(sd_sclk_o),
        .sd_csn_o(sd_csn_o), .sd_mosi_o(sd_mosi_o),
        .display_o(display_o),
        .rsp_valid_o(rsp_valid_o), .rsp_we_o(rsp_we_o), .rsp_rdata_o(rsp_rdata_o)
    );

endmodule

// File: verif/tb_tests.svh
//------------------------------
// Directed tests for the peripheral bus
//------------------------------
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

function automatic logic [ADDR_W-1:0] reg_addr(input logic [3:0] dev, input logic [11:0] ofs);
    return {REGION_PERIPH, 12'h000, dev, ofs};
endfunction

task automatic idle(input int n);
    repeat (n) begin
        @(posedge clk);
        #10;
    end
endtask

// Spends one credit and waits first if none is left
task automatic send_req(input logic we, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] rdata);
    bus_rsp_t want;
    while (credits == 0) begin
        idle(1);
    end
    want.rdata = we ? '0 : rdata;
    exp_rdata_q.push_back(want);
    exp_we_q.push_back(we);
    credits--;
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    idle(1);
    req_valid_i = 1'b0;
endtask

task automatic wait_responses();
    while (exp_we_q.size() != 0) begin
        idle(1);
    end
endtask

task automatic check_reset_values();
    check_bit("req_credit_o", req_credit_o, 1'b0);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("uart_tx_strobe_o", uart_tx_strobe_o, 1'b0);
    check_code("display_o", display_o, 8'h00);
    check_bit("sd_csn_o", sd_csn_o, 1'b1);
    check_bit("sd_sclk_o", sd_sclk_o, 1'b0);
    check_bit("sd_mosi_o", sd_mosi_o, 1'b0);
endtask

task automatic display_write_readback();
    logic [DATA_W-1:0] data;
    data = $urandom();
    send_req(1'b1, reg_addr(DEV_DISPLAY, OFS_DATA), data, '0);
    // Display is write only
    send_req(1'b0, reg_addr(DEV_DISPLAY, OFS_DATA), '0, '0);
    send_req(1'b0, reg_addr(4'h3, OFS_DATA), '0, '0);
    send_req(1'b0, reg_addr(DEV_UART, 12'h008), '0, '0);
    send_req(1'b0, 32'h1000_1000, '0, '0);
    wait_responses();
    check_code("display_o", display_o, data[7:0]);
endtask

task automatic uart_transmit();
    logic [DATA_W-1:0] data;
    data = $urandom();
    tx_count = 0;
    send_req(1'b1, reg_addr(DEV_UART, OFS_DATA), data, '0);
    wait_responses();
    if (tx_count != 1) begin
        stop_with_failure("UART write did not give exactly one transmit strobe");
    end
    check_code("uart_tx_data_o", tx_last, data[7:0]);
    uart_tx_busy_i = 1'b1;
    send_req(1'b0, reg_addr(DEV_UART, OFS_STATUS), '0, 32'h1);
    wait_responses();
    uart_tx_busy_i = 1'b0;
    send_req(1'b0, reg_addr(DEV_UART, OFS_STATUS), '0, 32'h0);
    wait_responses();
endtask

task automatic uart_receive_order();
    code_t bytes [4];
    for (int i = 0; i < 4; i++) begin
        bytes[i]        = code_t'($urandom());
        uart_rx_valid_i = 1'b1;
        uart_rx_data_i  = bytes[i];
        idle(1);
    end
    uart_rx_valid_i = 1'b0;
    idle(3);
    send_req(1'b0, reg_addr(DEV_UART, OFS_STATUS), '0, 32'h2);
    // Pop into the latch and then read it
    for (int i = 0; i < 4; i++) begin
        send_req(1'b1, reg_addr(DEV_UART, OFS_STATUS), $urandom(), '0);
        send_req(1'b0, reg_addr(DEV_UART, OFS_DATA), '0, {24'h0, bytes[i]});
    end
    send_req(1'b0, reg_addr(DEV_UART, OFS_STATUS), '0, 32'h0);
    wait_responses();
endtask

task automatic kbd_overflow_drop();
    code_t codes [KBD_DEPTH+2];
    for (int i = 0; i < KBD_DEPTH + 2; i++) begin
        codes[i]     = code_t'($urandom());
        kbd_strobe_i = 1'b1;
        kbd_code_i   = codes[i];
        idle(1);
    end
    kbd_strobe_i = 1'b0;
    idle(3);
    send_req(1'b0, reg_addr(DEV_KBD, OFS_DATA), '0, 32'h3);
    for (int i = 0; i < KBD_DEPTH; i++) begin
        send_req(1'b1, reg_addr(DEV_KBD, OFS_DATA), '0, '0);
        send_req(1'b0, reg_addr(DEV_KBD, OFS_CODE), '0, {24'h0, codes[i]});
    end
    // Queue now empty while overflow stays set
    send_req(1'b0, reg_addr(DEV_KBD, OFS_DATA), '0, 32'h2);
    wait_responses();
endtask

task automatic sd_pin_control();
    logic [DATA_W-1:0] data;
    for (int v = 0; v < 8; v++) begin
        data      = $urandom();
        data[2:0] = v[2:0];
        send_req(1'b1, reg_addr(DEV_SD, OFS_DATA), data, '0);
        wait_responses();
        check_bit("sd_sclk_o", sd_sclk_o, data[2]);
        check_bit("sd_csn_o", sd_csn_o, !data[1]);
        check_bit("sd_mosi_o", sd_mosi_o, data[0]);
    end
    for (int m = 0; m < 2; m++) begin
        sd_miso_i = m[0];
        send_req(1'b0, reg_addr(DEV_SD, OFS_DATA), '0, {31'h0, m[0]});
        wait_responses();
    end
    sd_miso_i = 1'b0;
endtask

task automatic request_credit_burst();
    if (credits != REQ_DEPTH) begin
        stop_with_failure("Request credits were not all back before the burst test");
    end
    uart_tx_busy_i = 1'b1;
    for (int b = 0; b < 3; b++) begin
        // Mixed targets so a reordered response shows up
        for (int i = 0; i < REQ_DEPTH; i++) begin
            case ((b + i) % 3)
                0:       send_req(1'b0, reg_addr(DEV_KBD, OFS_DATA), '0, 32'h2);
                1:       send_req(1'b0, reg_addr(DEV_UART, OFS_STATUS), '0, 32'h1);
                default: send_req(1'b1, reg_addr(DEV_DISPLAY, OFS_DATA), $urandom(), '0);
            endcase
        end
        while (credits < REQ_DEPTH) begin
            idle(1);
        end
    end
    wait_responses();
    uart_tx_busy_i = 1'b0;
endtask

`endif

// File: verif/tb_periph_bus_top.sv
//------------------------------
// Peripheral bus testbench
// Credit master, response checker, directed tests
//------------------------------
`timescale 1ns/1ns

module tb_periph_bus_top import periph_pkg::*; ();

    // Directed tests take about 150 cycles
    localparam int MAX_CYCLES = 2000;
    localparam logic [31:0] SEED = 32'hf6993964;

    logic              clk = 1'b0;
    logic              reset_i;
    logic              req_valid_i;
    logic              req_we_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [DATA_W-1:0] req_wdata_i;
    logic              req_credit_o;
    logic              rsp_valid_o;
    logic              rsp_we_o;
    bus_rsp_t          rsp_rdata_o;
    logic              uart_rx_valid_i;
    code_t             uart_rx_data_i;
    logic              uart_tx_busy_i;
    logic              uart_tx_strobe_o;
    code_t             uart_tx_data_o;
    logic              kbd_strobe_i;
    code_t             kbd_code_i;
    logic              sd_miso_i;
    logic              sd_sclk_o;
    logic              sd_csn_o;
    logic              sd_mosi_o;
    logic [7:0]        display_o;

    // Master side bookkeeping
    int       credits = REQ_DEPTH;
    int       cycles = 0;
    int       tx_count = 0;
    code_t    tx_last;
    bus_rsp_t exp_rdata_q[$];
    logic     exp_we_q[$];

    always #50 clk = ~clk;

    periph_bus_top UUT (.*);

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_code(input string name, input code_t got, input code_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            stop_with_failure("Timeout: the run did not finish within the cycle limit");
        end
    end

    // Outputs are stable mid cycle
    always @(negedge clk) begin
        if (!reset_i) begin
            if (req_credit_o) begin
                credits++;
                if (credits > REQ_DEPTH) begin
                    stop_with_failure("More request credits came back than were spent");
                end
            end
            if (uart_tx_strobe_o) begin
                tx_count++;
                tx_last = uart_tx_data_o;
            end
            if (rsp_valid_o) begin
                if (exp_we_q.size() == 0) begin
                    stop_with_failure("A response arrived with no request outstanding");
                end else begin
                    check_bit("rsp_we_o", rsp_we_o, exp_we_q.pop_front());
                    check_rsp("rsp_rdata_o", rsp_rdata_o, exp_rdata_q.pop_front());
                end
            end
        end
    end

    `include "tb_tests.svh"

    initial begin
        void'($urandom(SEED));
        reset_i         = 1'b1;
        req_valid_i     = 1'b0;
        req_we_i        = 1'b0;
        req_addr_i      = '0;
        req_wdata_i     = '0;
        uart_rx_valid_i = 1'b0;
        uart_rx_data_i  = '0;
        uart_tx_busy_i  = 1'b0;
        kbd_strobe_i    = 1'b0;
        kbd_code_i      = '0;
        sd_miso_i       = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        reset_i = 1'b0;

        check_reset_values();
        display_write_readback();
        uart_transmit();
        uart_receive_order();
        kbd_overflow_drop();
        sd_pin_control();
        request_credit_burst();

        // Quiet cycles so a stray response or credit still gets caught
        idle(5);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: periph_bus_top.f
+incdir+verif
hdl/periph_pkg.sv
hdl/credit_fifo.sv
hdl/code_capture.sv
hdl/addr_decode.sv
hdl/periph_regs.sv
hdl/periph_bus_top.sv
verif/tb_periph_bus_top.sv
